// ==== common/fetch_pkg.sv ====
// shared widths, table sizes, opcodes and counter encodings for the fetch front end
`default_nettype none

package fetch_pkg;

	////////////////////
	// datapath widths
	////////////////////
	localparam int xlen       = 64;                 // pc and address width
	localparam int inst_width = 32;                 // one instruction
	localparam int imem_width = 64;                 // memory returns two instructions

	////////////////////
	// table geometry
	////////////////////
	localparam int btb_entries     = 16;
	localparam int btb_index_bits  = 4;             // pc[5:2]
	localparam int btb_tag_bits    = xlen - btb_index_bits - 2; // rest of the pc above the index
	localparam int lht_entries     = 16;            // local history table, pc indexed
	localparam int lht_index_bits  = $clog2(lht_entries);
	localparam int local_hist_bits = 4;             // also indexes the local pattern table
	localparam int ghr_bits        = 4;             // global history, xor'd with pc[5:2]
	localparam int chooser_entries = 16;
	localparam int chooser_index_bits = $clog2(chooser_entries);

	////////////////////
	// predecode opcodes
	////////////////////
	localparam logic [6:0] opcode_branch = 7'b1100011; // beq/bne/blt/...
	localparam logic [6:0] opcode_jal    = 7'b1101111;
	localparam logic [6:0] opcode_jalr   = 7'b1100111;

	// 2-bit counters start weakly not-taken; chooser reads this as weakly local
	localparam logic [1:0] counter_reset = 2'b01;

endpackage

`default_nettype wire

// ==== fetch/branch_predictor.sv ====
// tournament direction predictor: local and global two-level tables with a per-pc chooser
`timescale 1ns/100ps
`default_nettype none

module branch_predictor (
	input  logic                       clock,
	input  logic                       reset,
	input  logic [fetch_pkg::xlen-1:0] pc,                   // fetch pc lookup
	output logic                       pred_taken,           // final tournament pick
	output logic                       pred_local_taken,
	output logic                       pred_global_taken,
	input  logic                       resolve_valid,
	input  logic [fetch_pkg::xlen-1:0] resolve_pc,
	input  logic                       resolve_cond,         // only conditionals train here
	input  logic                       resolve_taken,
	input  logic                       resolve_local_taken,  // what each side said at fetch
	input  logic                       resolve_global_taken
);

	localparam int lpt_entries = 2 ** fetch_pkg::local_hist_bits;
	localparam int gpt_entries = 2 ** fetch_pkg::ghr_bits;

	logic [fetch_pkg::local_hist_bits-1:0] lht [fetch_pkg::lht_entries];     // per-pc histories
	logic [1:0]                            lpt [lpt_entries];                // local counters
	logic [1:0]                            gpt [gpt_entries];                // global counters
	logic [1:0]                            chooser [fetch_pkg::chooser_entries]; // 1x prefers global
	logic [fetch_pkg::ghr_bits-1:0]        ghr;

	logic [fetch_pkg::lht_index_bits-1:0]     f_lht_idx, r_lht_idx;
	logic [fetch_pkg::chooser_index_bits-1:0] f_ch_idx, r_ch_idx;
	logic [fetch_pkg::local_hist_bits-1:0]    f_lpt_idx, r_lpt_idx;
	logic [fetch_pkg::ghr_bits-1:0]           f_gpt_idx, r_gpt_idx;
	logic                                     train;

	// saturating step of a 2-bit counter
	function automatic logic [1:0] sat_step(input logic [1:0] cnt, input logic up);
		logic [1:0] res;
		res = cnt;
		if (up && cnt != 2'b11) res = cnt + 2'd1;
		else if (!up && cnt != 2'b00) res = cnt - 2'd1;
		return res;
	endfunction

	////////////////////
	// lookup side
	////////////////////
	assign f_lht_idx = pc[fetch_pkg::lht_index_bits+1:2];
	assign f_ch_idx  = pc[fetch_pkg::chooser_index_bits+1:2];
	assign f_lpt_idx = lht[f_lht_idx];                        // second level via history
	assign f_gpt_idx = ghr ^ pc[fetch_pkg::ghr_bits+1:2];     // gshare style

	assign pred_local_taken  = lpt[f_lpt_idx][1];
	assign pred_global_taken = gpt[f_gpt_idx][1];
	assign pred_taken = chooser[f_ch_idx][1] ? pred_global_taken : pred_local_taken;

	////////////////////
	// resolve side
	////////////////////
	assign train     = resolve_valid && resolve_cond;
	assign r_lht_idx = resolve_pc[fetch_pkg::lht_index_bits+1:2];
	assign r_ch_idx  = resolve_pc[fetch_pkg::chooser_index_bits+1:2];
	assign r_lpt_idx = lht[r_lht_idx];                        // history before this outcome
	assign r_gpt_idx = ghr ^ resolve_pc[fetch_pkg::ghr_bits+1:2];

	always_ff @(posedge clock) begin
		if (reset) begin
			ghr <= '0;
			for (int i = 0; i < fetch_pkg::lht_entries; i++) lht[i] <= '0;
			for (int i = 0; i < lpt_entries; i++) lpt[i] <= fetch_pkg::counter_reset;
			for (int i = 0; i < gpt_entries; i++) gpt[i] <= fetch_pkg::counter_reset;
			for (int i = 0; i < fetch_pkg::chooser_entries; i++) begin
				chooser[i] <= fetch_pkg::counter_reset; // weakly local
			end
		end else if (train) begin
			lpt[r_lpt_idx] <= sat_step(lpt[r_lpt_idx], resolve_taken);
			gpt[r_gpt_idx] <= sat_step(gpt[r_gpt_idx], resolve_taken);
			// chooser only moves when the two sides disagreed in correctness
			if ((resolve_local_taken == resolve_taken) != (resolve_global_taken == resolve_taken)) begin
				chooser[r_ch_idx] <= sat_step(chooser[r_ch_idx],
				                              resolve_global_taken == resolve_taken);
			end
			// shift the outcome into both histories
			lht[r_lht_idx] <= {lht[r_lht_idx][fetch_pkg::local_hist_bits-2:0], resolve_taken};
			ghr            <= {ghr[fetch_pkg::ghr_bits-2:0], resolve_taken};
		end
	end

endmodule

`default_nettype wire

// ==== fetch/btb.sv ====
// direct-mapped branch target buffer, looked up by the fetch pc and written by taken resolves
`timescale 1ns/100ps
`default_nettype none

module btb (
	input  logic                       clock,
	input  logic                       reset,
	input  logic [fetch_pkg::xlen-1:0] pc,
	output logic                       btb_hit,
	output logic [fetch_pkg::xlen-1:0] btb_target,
	input  logic                       resolve_valid,
	input  logic [fetch_pkg::xlen-1:0] resolve_pc,
	input  logic                       resolve_cond,
	input  logic                       resolve_uncond,
	input  logic                       resolve_taken,
	input  logic [fetch_pkg::xlen-1:0] resolve_target
);

	logic                               valid  [fetch_pkg::btb_entries];
	logic [fetch_pkg::btb_tag_bits-1:0] tags   [fetch_pkg::btb_entries];
	logic [fetch_pkg::xlen-1:0]         target [fetch_pkg::btb_entries];

	logic [fetch_pkg::btb_index_bits-1:0] f_idx, r_idx;
	logic [fetch_pkg::btb_tag_bits-1:0]   f_tag, r_tag;
	logic                                 wr_en;

	////////////////////
	// lookup
	////////////////////
	assign f_idx = pc[fetch_pkg::btb_index_bits+1:2];             // word index, pc[5:2]
	assign f_tag = pc[fetch_pkg::xlen-1:fetch_pkg::btb_index_bits+2]; // everything above

	assign btb_hit    = valid[f_idx] && (tags[f_idx] == f_tag);
	assign btb_target = target[f_idx];

	////////////////////
	// update
	////////////////////
	assign r_idx = resolve_pc[fetch_pkg::btb_index_bits+1:2];
	assign r_tag = resolve_pc[fetch_pkg::xlen-1:fetch_pkg::btb_index_bits+2];
	// only taken branches or jumps allocate; not-taken leaves the old entry
	assign wr_en = resolve_valid && (resolve_cond || resolve_uncond) && resolve_taken;

	// valid bits, set by a taken resolve
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < fetch_pkg::btb_entries; i++) valid[i] <= 1'b0;
		end else if (wr_en) begin
			valid[r_idx] <= 1'b1;
		end
	end

	// tag and target of the newest taken resolve at this index
	always_ff @(posedge clock) begin
		if (wr_en) begin
			tags[r_idx]   <= r_tag;
			target[r_idx] <= resolve_target;
		end
	end

endmodule

`default_nettype wire

// ==== fetch/if_stage.sv ====
// fetch stage: holds the pc, picks the instruction half, predecodes it and selects the next pc
`timescale 1ns/100ps
`default_nettype none

module if_stage (
	input  logic                             clock,
	input  logic                             reset,
	output logic [fetch_pkg::xlen-1:0]       imem_addr,  // 8-byte aligned fetch address
	input  logic [fetch_pkg::imem_width-1:0] imem_data,  // comes back in the same cycle
	output logic [fetch_pkg::xlen-1:0]       pc,         // current fetch pc, goes to btb and predictor
	input  logic                             btb_hit,
	input  logic [fetch_pkg::xlen-1:0]       btb_target,
	input  logic                             pred_taken, // tournament direction for this pc
	input  logic                             redirect_valid,
	input  logic [fetch_pkg::xlen-1:0]       redirect_pc,
	output logic [fetch_pkg::inst_width-1:0] fetch_inst,
	output logic [fetch_pkg::xlen-1:0]       fetch_npc,  // predicted next pc
	output logic                             fetch_pred_taken
);

	logic [fetch_pkg::xlen-1:0] pc_plus_4;
	logic [fetch_pkg::xlen-1:0] next_pc;
	logic [6:0]                 opcode;
	logic                       is_cond;   // conditional branch
	logic                       is_uncond; // jal or jalr
	logic                       take_btb;

	////////////////////
	// memory side
	////////////////////
	assign imem_addr = {pc[fetch_pkg::xlen-1:3], 3'b000}; // memory is 64 bits wide

	// pc[2] picks the upper instruction of the pair
	assign fetch_inst = pc[2] ? imem_data[fetch_pkg::imem_width-1:fetch_pkg::inst_width]
	                          : imem_data[fetch_pkg::inst_width-1:0];

	////////////////////
	// predecode
	////////////////////
	assign opcode    = fetch_inst[6:0];
	assign is_cond   = (opcode == fetch_pkg::opcode_branch);
	assign is_uncond = (opcode == fetch_pkg::opcode_jal) || (opcode == fetch_pkg::opcode_jalr);

	////////////////////
	// next pc
	////////////////////
	assign pc_plus_4 = pc + fetch_pkg::xlen'(4);

	// without a btb entry there is no target whatever the opcode says
	assign take_btb = btb_hit && (is_uncond || (is_cond && pred_taken));

	assign fetch_npc        = take_btb ? btb_target : pc_plus_4;
	assign fetch_pred_taken = take_btb;

	// the back end wins over any prediction
	assign next_pc = redirect_valid ? redirect_pc : fetch_npc;

	// pc register advances every clock since nothing stalls fetch
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;            // boot from address 0
		end else begin
			pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

// ==== fetch_unit.f ====
common/fetch_pkg.sv
fetch/if_stage.sv
fetch/branch_predictor.sv
fetch/btb.sv
rtl/fetch_unit.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

// ==== rtl/fetch_unit.sv ====
// fetch front end top: connects the fetch stage to the btb and the tournament predictor
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
	input  logic                             clock,
	input  logic                             reset,
	output logic [fetch_pkg::xlen-1:0]       imem_addr,
	input  logic [fetch_pkg::imem_width-1:0] imem_data,
	input  logic                             redirect_valid,  // one-cycle strobe from back end
	input  logic [fetch_pkg::xlen-1:0]       redirect_pc,
	input  logic                             resolve_valid,   // one-cycle resolve strobe
	input  logic [fetch_pkg::xlen-1:0]       resolve_pc,
	input  logic                             resolve_cond,
	input  logic                             resolve_uncond,
	input  logic                             resolve_taken,
	input  logic [fetch_pkg::xlen-1:0]       resolve_target,
	input  logic                             resolve_local_taken,
	input  logic                             resolve_global_taken,
	output logic [fetch_pkg::inst_width-1:0] fetch_inst,
	output logic [fetch_pkg::xlen-1:0]       fetch_pc,
	output logic [fetch_pkg::xlen-1:0]       fetch_npc,
	output logic                             fetch_pred_taken,
	output logic                             pred_local_taken,  // carried along for training
	output logic                             pred_global_taken
);

	logic                       btb_hit;
	logic [fetch_pkg::xlen-1:0] btb_target;
	logic                       pred_taken;

	////////////////////
	// fetch stage pc drives both lookups
	////////////////////
	if_stage u_if_stage (
		.clock, .reset, .imem_addr, .imem_data,
		.pc               (fetch_pc),
		.btb_hit, .btb_target, .pred_taken,
		.redirect_valid, .redirect_pc,
		.fetch_inst, .fetch_npc, .fetch_pred_taken
	);

	branch_predictor u_branch_predictor (
		.clock, .reset,
		.pc               (fetch_pc),
		.pred_taken, .pred_local_taken, .pred_global_taken,
		.resolve_valid, .resolve_pc, .resolve_cond, .resolve_taken,
		.resolve_local_taken, .resolve_global_taken
	);

	btb u_btb (
		.clock, .reset,
		.pc               (fetch_pc),
		.btb_hit, .btb_target,
		.resolve_valid, .resolve_pc, .resolve_cond, .resolve_uncond,
		.resolve_taken, .resolve_target
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# builds the fetch testbench with verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f fetch_unit.f --top-module fetch_tb \
	-Mdir obj_dir -o fetch_sim > /dev/null &&
sim_out="$(./obj_dir/fetch_sim)" &&
echo "$sim_out" &&
echo "$sim_out" | grep -qx "Result: PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tests/fetch_checker.sv ====
// reference model of the fetch front end; compares the DUT ports every cycle and counts errors
`timescale 1ns/100ps
`default_nettype none

module fetch_checker (
	input  logic        clock,
	input  logic        reset,
	input  int          test_num,             // 0 while idle or in reset
	input  logic [63:0] imem_addr,
	input  logic [63:0] imem_data,
	input  logic        redirect_valid,
	input  logic [63:0] redirect_pc,
	input  logic        resolve_valid,
	input  logic [63:0] resolve_pc,
	input  logic        resolve_cond,
	input  logic        resolve_uncond,
	input  logic        resolve_taken,
	input  logic [63:0] resolve_target,
	input  logic        resolve_local_taken,
	input  logic        resolve_global_taken,
	input  logic [31:0] fetch_inst,
	input  logic [63:0] fetch_pc,
	input  logic [63:0] fetch_npc,
	input  logic        fetch_pred_taken,
	input  logic        pred_local_taken,     // component predictions for the back end
	input  logic        pred_global_taken,
	output int          errors,
	output int          checks
);

	// model state
	logic [63:0] m_pc;
	logic        m_valid [16];
	logic [57:0] m_tag [16];          // pc[63:6]
	logic [63:0] m_target [16];
	logic [3:0]  m_lht [16];
	logic [1:0]  m_lpt [16];
	logic [1:0]  m_gpt [16];
	logic [1:0]  m_chooser [16];
	logic [3:0]  m_ghr;

	// per-cycle expectations
	logic [31:0] e_inst;
	logic [6:0]  e_op;
	logic [3:0]  idx;
	logic        e_cond, e_uncond, e_hit, e_local, e_global, e_dir, e_path;
	logic [63:0] e_npc;
	int          cur_test    = 0;
	int          test_checks = 0;
	int          test_errors = 0;

	initial begin
		errors = 0;
		checks = 0;
	end

	// two-bit saturating counter
	function automatic logic [1:0] counter_next(input logic [1:0] cnt, input logic up);
		if (up)
			return (cnt == 2'd3) ? cnt : cnt + 2'd1;
		return (cnt == 2'd0) ? cnt : cnt - 2'd1;
	endfunction

	task automatic compare_value(input string name, input logic [63:0] expected,
	                             input logic [63:0] actual);
		checks++;
		test_checks++;
		if (actual !== expected) begin
			errors++;
			test_errors++;
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic reset_model();
		m_pc  = 64'd0;
		m_ghr = 4'd0;
		for (int i = 0; i < 16; i++) begin
			m_valid[i]   = 1'b0;
			m_lht[i]     = 4'd0;
			m_lpt[i]     = 2'd1;     // weakly not-taken
			m_gpt[i]     = 2'd1;
			m_chooser[i] = 2'd1;     // weakly local
		end
	endtask

	////////////////////
	// table training from the resolve strobe
	////////////////////
	task automatic apply_resolve();
		logic [3:0] r_idx;
		logic [3:0] hist;
		logic [3:0] g_idx;
		logic       local_ok;
		logic       global_ok;
		r_idx     = resolve_pc[5:2];
		hist      = m_lht[r_idx];          // history before this outcome
		g_idx     = m_ghr ^ r_idx;
		local_ok  = (resolve_local_taken == resolve_taken);
		global_ok = (resolve_global_taken == resolve_taken);
		if ((resolve_cond || resolve_uncond) && resolve_taken) begin
			m_valid[r_idx]  = 1'b1;
			m_tag[r_idx]    = resolve_pc[63:6];
			m_target[r_idx] = resolve_target;
		end
		if (resolve_cond) begin
			m_lpt[hist]  = counter_next(m_lpt[hist], resolve_taken);
			m_gpt[g_idx] = counter_next(m_gpt[g_idx], resolve_taken);
			if (local_ok != global_ok)
				m_chooser[r_idx] = counter_next(m_chooser[r_idx], global_ok);
			m_lht[r_idx] = {hist[2:0], resolve_taken};
			m_ghr        = {m_ghr[2:0], resolve_taken};
		end
	endtask

	// inputs change 1 ns after the rising edge, so the falling edge sees them settled
	always @(negedge clock) begin
		if (reset) begin
			reset_model();
			cur_test = 0;
		end else begin
			if (test_num != cur_test) begin
				if (cur_test != 0)
					$display("test %0d finished: %0d checks, %0d errors", cur_test,
					         test_checks, test_errors);
				cur_test    = test_num;
				test_checks = 0;
				test_errors = 0;
			end
			idx      = m_pc[5:2];
			e_inst   = m_pc[2] ? imem_data[63:32] : imem_data[31:0];
			e_op     = e_inst[6:0];
			e_cond   = (e_op == 7'b1100011);
			e_uncond = (e_op == 7'b1101111) || (e_op == 7'b1100111);
			e_hit    = m_valid[idx] && (m_tag[idx] == m_pc[63:6]);
			e_local  = m_lpt[m_lht[idx]][1];
			e_global = m_gpt[m_ghr ^ idx][1];
			// chooser top bit set means trust the global side
			e_dir    = m_chooser[idx][1] ? e_global : e_local;
			e_path   = e_hit && (e_uncond || (e_cond && e_dir));
			e_npc    = e_path ? m_target[idx] : m_pc + 64'd4;
			compare_value("fetch_pc", m_pc, fetch_pc);
			compare_value("imem_addr", {m_pc[63:3], 3'b000}, imem_addr);
			compare_value("fetch_inst", 64'(e_inst), 64'(fetch_inst));
			compare_value("fetch_npc", e_npc, fetch_npc);
			compare_value("fetch_pred_taken", 64'(e_path), 64'(fetch_pred_taken));
			compare_value("pred_local_taken", 64'(e_local), 64'(pred_local_taken));
			compare_value("pred_global_taken", 64'(e_global), 64'(pred_global_taken));
			if (resolve_valid)
				apply_resolve();
			m_pc = redirect_valid ? redirect_pc : e_npc;   // redirect beats prediction
		end
	end

endmodule

`default_nettype wire

// ==== tests/fetch_tb.sv ====
// testbench top for the fetch front end; runs a stimulus table against fetch_unit under the checker
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;

	typedef struct packed {
		int          test;
		logic        redir_valid;
		logic [63:0] redir_pc;
		logic        res_valid;
		logic [63:0] res_pc;
		logic        cond;
		logic        uncond;
		logic        taken;
		logic [63:0] target;
		logic        local_taken;
		logic        global_taken;
	} row_t;

	logic        clock, reset;
	logic [63:0] imem_addr, imem_data, redirect_pc, resolve_pc, resolve_target;
	logic        redirect_valid, resolve_valid, resolve_cond, resolve_uncond, resolve_taken;
	logic        resolve_local_taken, resolve_global_taken;
	logic [31:0] fetch_inst;
	logic [63:0] fetch_pc, fetch_npc;
	logic        fetch_pred_taken, pred_local_taken, pred_global_taken;
	logic [63:0] imem [64];      // 512 bytes that wrap on higher addresses
	row_t        rows [$];
	int          test_num    = 0;
	int          errors, checks;
	int          cycle_count = 0;
	int          cycle_limit = 1000;

	always #2 clock = ~clock;    // 4 ns period
	assign imem_data = imem[imem_addr[8:3]];   // combinational read

	fetch_unit dut_i (
		.clock, .reset, .imem_addr, .imem_data, .redirect_valid, .redirect_pc,
		.resolve_valid, .resolve_pc, .resolve_cond, .resolve_uncond, .resolve_taken,
		.resolve_target, .resolve_local_taken, .resolve_global_taken,
		.fetch_inst, .fetch_pc, .fetch_npc, .fetch_pred_taken,
		.pred_local_taken, .pred_global_taken
	);

	fetch_checker check_i (
		.clock, .reset, .test_num, .imem_addr, .imem_data, .redirect_valid, .redirect_pc,
		.resolve_valid, .resolve_pc, .resolve_cond, .resolve_uncond, .resolve_taken,
		.resolve_target, .resolve_local_taken, .resolve_global_taken,
		.fetch_inst, .fetch_pc, .fetch_npc, .fetch_pred_taken,
		.pred_local_taken, .pred_global_taken, .errors, .checks
	);

	// non-branch filler whose upper bits follow the byte address
	function automatic logic [31:0] filler_inst(input logic [8:0] addr);
		logic [6:0] ops [4];
		ops = '{7'b0010011, 7'b0110011, 7'b0000011, 7'b0100011};
		return {25'(addr) ^ 25'h0a5a5a0, ops[2'($urandom % 4)]};
	endfunction

	task automatic place_inst(input logic [8:0] addr, input logic [31:0] inst);
		if (addr[2]) imem[addr[8:3]][63:32] = inst;
		else imem[addr[8:3]][31:0] = inst;
	endtask

	task automatic add_row(input int test, input logic rv, input logic [63:0] rpc,
	                       input logic sv, input logic [63:0] spc, input logic cond,
	                       input logic uncond, input logic taken, input logic [63:0] target,
	                       input logic lt, input logic gt);
		rows.push_back('{test, rv, rpc, sv, spc, cond, uncond, taken, target, lt, gt});
	endtask

	task automatic add_idle(input int test, input int n);
		repeat (n) add_row(test, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	endtask

	task automatic drive_row(input row_t r);
		test_num             = r.test;
		redirect_valid       = r.redir_valid;
		redirect_pc          = r.redir_pc;
		resolve_valid        = r.res_valid;
		resolve_pc           = r.res_pc;
		resolve_cond         = r.cond;
		resolve_uncond       = r.uncond;
		resolve_taken        = r.taken;
		resolve_target       = r.target;
		resolve_local_taken  = r.local_taken;
		resolve_global_taken = r.global_taken;
	endtask

	////////////////////
	// timeout watchdog
	////////////////////
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run went past %0d cycles without finishing", cycle_limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		drive_row('0);
		void'($urandom(3));
		for (int i = 0; i < 64; i++) begin
			imem[i][31:0]  = filler_inst(9'(i * 8));
			imem[i][63:32] = filler_inst(9'(i * 8 + 4));
		end
		place_inst(9'h010, 32'h00208463);   // beq
		place_inst(9'h014, 32'h0ec0006f);   // jal
		place_inst(9'h030, 32'h00008067);   // jalr
		place_inst(9'h040, 32'h04208063);   // beq, trained loop branch

		////////////////////
		// stimulus table
		////////////////////
		add_idle(1, 6);                                    // straight line from 0
		add_row(2, 1, 64'h10, 0, 0, 0, 0, 0, 0, 0, 0);     // branches with no btb entry
		add_idle(2, 3);
		add_row(3, 0, 0, 1, 64'h14, 0, 1, 1, 64'h100, 0, 0);
		add_row(3, 1, 64'h10, 0, 0, 0, 0, 0, 0, 0, 0);
		add_idle(3, 3);
		add_row(3, 0, 0, 1, 64'h14, 0, 1, 1, 64'h180, 0, 0);   // new target replaces
		add_row(3, 1, 64'h14, 0, 0, 0, 0, 0, 0, 0, 0);
		add_idle(3, 2);
		for (int i = 0; i < 8; i++) begin                  // train taken
			add_row(4, 0, 0, 1, 64'h40, 1, 0, 1, 64'h80, logic'(i >= 3), 0);
			add_row(4, 1, 64'h40, 0, 0, 0, 0, 0, 0, 0, 0);
			add_idle(4, 2);
		end
		for (int i = 0; i < 6; i++) begin                  // train back to not-taken
			add_row(4, 0, 0, 1, 64'h40, 1, 0, 0, 64'h80, 1, 1);
			add_row(4, 1, 64'h40, 0, 0, 0, 0, 0, 0, 0, 0);
			add_idle(4, 2);
		end
		add_row(5, 1, 64'h14, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row(5, 1, 64'h30, 0, 0, 0, 0, 0, 0, 0, 0);     // pc 0x14 hits, redirect wins
		add_idle(5, 2);
		add_row(6, 1, 64'h40, 1, 64'h40, 1, 0, 1, 64'h88, 0, 1);
		add_idle(6, 2);
		add_row(6, 1, 64'h14, 1, 64'h14, 0, 1, 1, 64'h1c0, 0, 0);
		add_idle(6, 2);
		cycle_limit = rows.size() + 50;

		repeat (10) @(posedge clock);
		#1 reset = 1'b0;
		foreach (rows[i]) begin
			drive_row(rows[i]);
			@(posedge clock);
			#1;
		end
		drive_row('0);                                     // test 0 closes the last report
		repeat (2) @(posedge clock);
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
